// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = step_motor_tb
FILELIST = step_motor.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Errors found
PASS_MSG = No errors

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/step_motor_props.sv
`include "step_motor_cfg.svh"

module step_motor_props
	import motion_pkg::*;
(
	input logic                    clk,
	input logic                    resetn,
	input logic [`MOTOR_NBR-1:0]   drive,
	input logic [`MOTOR_NBR-1:0]   busy,
	input speed_t [`MOTOR_NBR-1:0] rt_speed,
	input logic                    table_ready
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;	// read by the testbench at the end

	drive_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		(drive & $past(drive)) == '0)
	else begin
		fail_count++;
		$error("drive high in two consecutive cycles");
	end

	drive_while_busy: assert property (@(posedge clk) disable iff (!resetn)
		(drive & ~busy) == '0)
	else begin
		fail_count++;
		$error("drive pulse on an axis that is not busy");
	end

	// first cycle out of reset
	quiet_after_reset: assert property (@(posedge clk)
		$rose(resetn) |-> (drive == '0 && busy == '0 && rt_speed == '0 && !table_ready))
	else begin
		fail_count++;
		$error("outputs not low after reset");
	end

endmodule

bind step_motor step_motor_props props_i (.*);

// File: bench/step_motor_tb.sv
`include "step_motor_cfg.svh"

module step_motor_tb
	import motion_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SLOTS = `SLOT_NBR;
	localparam int TEST_CYCLES = 6 * 12 * SLOTS + 100;	// slowest entry times most steps
	localparam int LIMIT_CYCLES = 6 * TEST_CYCLES + 500;

	logic clk = 1'b0;
	logic resetn;
	logic br_init;
	logic br_wr_en;
	speed_t br_data;
	logic [`MOTOR_NBR-1:0] start;
	logic [`MOTOR_NBR-1:0] stop;
	step_t [`MOTOR_NBR-1:0] step;
	logic [`MOTOR_NBR-1:0] dir_in;
	logic [`MOTOR_NBR-1:0] drive;
	logic [`MOTOR_NBR-1:0] dir;
	logic [`MOTOR_NBR-1:0] busy;
	speed_t [`MOTOR_NBR-1:0] rt_speed;
	logic table_ready;

	int cyc = 0;
	int table_q[$];	// model of the loaded table

	step_motor dut_i (.*);

	always #2 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	task automatic check(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic load_table(input string name, input int n);
		int v;
		table_q.delete();
		@(negedge clk);
		br_init = 1'b1;
		for (int k = 0; k < n; k++) begin
			v = $urandom_range(6, 1);
			table_q.push_back(v);
			@(negedge clk);
			br_wr_en = 1'b1;
			br_data = speed_t'(v);
			check({name, " ready during load"}, 0, int'(table_ready));
		end
		@(negedge clk);
		br_wr_en = 1'b0;
		br_init = 1'b0;
		@(negedge clk);
		check({name, " ready after load"}, 1, int'(table_ready));
	endtask

	// starts one axis and records pulse times until it goes idle
	task automatic run_axis(input string name, input int ax, input int n, input bit d,
			input int stop_after);
		int times[$];
		int last;
		last = table_q.size() - 1;
		@(negedge clk);
		step[ax] = step_t'(n);
		dir_in[ax] = d;
		start[ax] = 1'b1;
		while (!busy[ax])
			@(negedge clk);
		start[ax] = 1'b0;
		while (busy[ax]) begin
			if (stop_after > 0 && times.size() >= stop_after)
				stop[ax] = 1'b1;	// cycle after the pulse
			if (drive[ax]) begin
				check({name, " speed"},
					table_q[(times.size() < last) ? times.size() : last],
					int'(rt_speed[ax]));
				times.push_back(cyc);
			end
			@(negedge clk);
		end
		stop[ax] = 1'b0;
		check({name, " pulses"}, (stop_after > 0) ? stop_after : n, times.size());
		for (int k = 1; k < times.size(); k++)
			check({name, " interval"}, table_q[(k < last) ? k : last] * SLOTS,
				times[k] - times[k-1]);
		check({name, " dir"}, int'(d), int'(dir[ax]));
		repeat (2 * SLOTS) begin
			@(negedge clk);
			check({name, " idle after run"}, 0, int'(drive[ax] | busy[ax]));
		end
	endtask

	task automatic reset_and_load();
		@(negedge clk);
		check("reset_and_load busy", 0, int'(busy));
		check("reset_and_load drive", 0, int'(drive));
		check("reset_and_load table_ready", 0, int'(table_ready));
		check("reset_and_load rt_speed", 0, int'(rt_speed != '0));
		load_table("reset_and_load", 12);
	endtask

	task automatic single_ramp();
		run_axis("single_ramp", 0, $urandom_range(12, 1), 1'b1, 0);
	endtask

	task automatic hold_last_speed();
		load_table("hold_last_speed", 3);	// shorter than the run
		run_axis("hold_last_speed", 1, 10, 1'b1, 0);
	endtask

	task automatic two_axes();
		int n0;
		int n1;
		n0 = $urandom_range(12, 1);
		n1 = n0 % 12 + 1;
		load_table("two_axes", 8);
		fork
			run_axis("two_axes axis0", 0, n0, 1'b0, 0);
			run_axis("two_axes axis1", 1, n1, 1'b0, 0);
		join
	endtask

	task automatic stop_mid_run();
		run_axis("stop_mid_run", 0, 10, 1'b1, 3);
	endtask

	task automatic start_without_table();
		@(negedge clk);
		br_init = 1'b1;
		@(negedge clk);
		step[0] = step_t'(4);
		start[0] = 1'b1;
		repeat (3 * SLOTS) begin
			@(negedge clk);
			check("start_without_table busy", 0, int'(busy[0]));
			check("start_without_table drive", 0, int'(drive[0]));
		end
		start[0] = 1'b0;
		br_init = 1'b0;
		@(negedge clk);
		check("start_without_table table_ready", 0, int'(table_ready));
	endtask

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("timeout, tests did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Errors found");
		$fatal(1);
	end

	initial begin
		void'($urandom(65758));
		resetn = 1'b0;
		br_init = 1'b0;
		br_wr_en = 1'b0;
		br_data = '0;
		start = '0;
		stop = '0;
		step = '0;
		dir_in = '0;
		repeat (5) @(negedge clk);
		resetn = 1'b1;
		reset_and_load();
		single_ramp();
		hold_last_speed();
		two_axes();
		stop_mid_run();
		start_without_table();
		if (dut_i.props_i.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("%0d assertion failures", dut_i.props_i.fail_count);
			$display("Errors found");
			$fatal(1);
		end
	end

endmodule

// File: source/motion_pkg.sv
`include "step_motor_cfg.svh"

package motion_pkg;

	// step period in scheduler slots
	typedef logic [`SPEED_W-1:0] speed_t;

	typedef logic [`STEP_W-1:0] step_t;

	typedef enum logic [1:0] {
		AXIS_IDLE,
		AXIS_FETCH,	// waiting for first period
		AXIS_RUN
	} axis_state_e;

endpackage

// File: source/slot_scheduler.sv
`include "step_motor_cfg.svh"

module slot_scheduler
	import table_pkg::*;
(
	input  logic                                 clk,
	input  logic                                 resetn,
	input  logic [`MOTOR_NBR-1:0]                rd_req,
	input  table_addr_t [`MOTOR_NBR-1:0]         rd_addr_axis,
	output logic [`MOTOR_NBR-1:0]                slot_en,
	output table_addr_t                          rd_addr
);
	logic [`SLOT_NBR-1:0] ring;
	table_addr_t addr_merge;

	always_ff @(posedge clk) begin
		if (!resetn)
			ring <= {{(`SLOT_NBR-1){1'b0}}, 1'b1};	// axis 0 owns cycle 0
		else
			ring <= {ring[`SLOT_NBR-2:0], ring[`SLOT_NBR-1]};
	end

	assign slot_en = ring[`MOTOR_NBR-1:0];	// upper bits are idle slots

	// only the slot owner may request, so an OR is enough
	always_comb begin
		addr_merge = '0;
		for (int i = 0; i < `MOTOR_NBR; i++) begin
			if (rd_req[i] && ring[i])
				addr_merge = addr_merge | rd_addr_axis[i];
		end
	end

	always_ff @(posedge clk) begin
		rd_addr <= addr_merge;	// first stage of the fetch path
	end

endmodule

// File: source/speed_table_loader.sv
module speed_table_loader
	import motion_pkg::*;
	import table_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        br_init,
	input  logic        br_wr_en,
	input  speed_t      br_data,
	output logic        wr_en,
	output table_addr_t wr_addr,
	output speed_t      wr_data,
	output table_addr_t last_index,
	output logic        table_ready
);
	load_state_e state;
	table_addr_t wr_index;

	assign wr_en = br_init && br_wr_en;	// strobes outside a load are dropped
	assign wr_addr = wr_index;
	assign wr_data = br_data;
	assign table_ready = (state == LOAD_READY);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= LOAD_EMPTY;
			wr_index <= '0;
			last_index <= '0;
		end else begin
			if (!br_init) begin
				wr_index <= '0;
			end else if (br_wr_en) begin
				wr_index <= wr_index + 1'b1;
				last_index <= wr_index;
			end
			case (state)
				LOAD_EMPTY: if (wr_en) state <= LOAD_FILL;
				LOAD_FILL: if (!br_init) state <= LOAD_READY;
				LOAD_READY: if (br_init) state <= wr_en ? LOAD_FILL : LOAD_EMPTY;	// new table
				default: state <= LOAD_EMPTY;
			endcase
		end
	end

endmodule

// File: source/speed_table_ram.sv
`include "step_motor_cfg.svh"

module speed_table_ram
	import motion_pkg::*;
	import table_pkg::*;
(
	input  logic        clk,
	input  logic        wr_en,
	input  table_addr_t wr_addr,
	input  speed_t      wr_data,
	input  table_addr_t rd_addr,
	output speed_t      rd_data
);
	localparam int DEPTH = 1 << `TABLE_AW;

	speed_t mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read, second stage of the fetch path
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: source/step_motor.sv
`include "step_motor_cfg.svh"

module step_motor
	import motion_pkg::*;
	import table_pkg::*;
(
	input  logic                         clk,
	input  logic                         resetn,
	input  logic                         br_init,
	input  logic                         br_wr_en,
	input  speed_t                       br_data,
	input  logic [`MOTOR_NBR-1:0]        start,
	input  logic [`MOTOR_NBR-1:0]        stop,
	input  step_t [`MOTOR_NBR-1:0]       step,
	input  logic [`MOTOR_NBR-1:0]        dir_in,
	output logic [`MOTOR_NBR-1:0]        drive,
	output logic [`MOTOR_NBR-1:0]        dir,
	output logic [`MOTOR_NBR-1:0]        busy,
	output speed_t [`MOTOR_NBR-1:0]      rt_speed,
	output logic                         table_ready
);
	logic wr_en;
	table_addr_t wr_addr;
	speed_t wr_data;
	table_addr_t last_index;
	table_addr_t rd_addr;
	speed_t rd_data;
	logic [`MOTOR_NBR-1:0] slot_en;
	logic [`MOTOR_NBR-1:0] rd_req;
	table_addr_t [`MOTOR_NBR-1:0] rd_addr_axis;

	speed_table_loader loader_i (
		.clk(clk),
		.resetn(resetn),
		.br_init(br_init),
		.br_wr_en(br_wr_en),
		.br_data(br_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.last_index(last_index),
		.table_ready(table_ready)
	);

	speed_table_ram ram_i (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	slot_scheduler sched_i (
		.clk(clk),
		.resetn(resetn),
		.rd_req(rd_req),
		.rd_addr_axis(rd_addr_axis),
		.slot_en(slot_en),
		.rd_addr(rd_addr)
	);

	genvar i;
	generate
		for (i = 0; i < `MOTOR_NBR; i++) begin : axis
			step_pulse_gen pulse_i (
				.clk(clk),
				.resetn(resetn),
				.slot_en(slot_en[i]),
				.table_ready(table_ready),
				.last_index(last_index),
				.rd_data(rd_data),	// shared, each axis captures its own slot
				.start(start[i]),
				.stop(stop[i]),
				.step(step[i]),
				.dir_in(dir_in[i]),
				.rd_req(rd_req[i]),
				.rd_addr(rd_addr_axis[i]),
				.drive(drive[i]),
				.dir(dir[i]),
				.busy(busy[i]),
				.rt_speed(rt_speed[i])
			);
		end
	endgenerate

endmodule

// File: source/step_motor_cfg.svh
`ifndef STEP_MOTOR_CFG_SVH
`define STEP_MOTOR_CFG_SVH

// width of a speed table entry, in slots
`define SPEED_W 16

// width of a step count
`define STEP_W 16

// 64 entry speed table
`define TABLE_AW 6

`define MOTOR_NBR 2

// ring length, at least MOTOR_NBR and at least 4 for the 2 cycle read
`define SLOT_NBR 8

`endif

// File: source/step_pulse_gen.sv
module step_pulse_gen
	import motion_pkg::*;
	import table_pkg::*;
(
	input  logic        clk,
	input  logic        resetn,
	input  logic        slot_en,
	input  logic        table_ready,
	input  table_addr_t last_index,
	input  speed_t      rd_data,
	input  logic        start,
	input  logic        stop,
	input  step_t       step,
	input  logic        dir_in,
	output logic        rd_req,
	output table_addr_t rd_addr,
	output logic        drive,
	output logic        dir,
	output logic        busy,
	output speed_t      rt_speed
);
	axis_state_e state;
	logic [1:0] req_d;	// own request, delayed to meet rd_data
	logic start_ok;
	logic last_pulse;
	step_t step_left;
	table_addr_t index;
	table_addr_t next_index;
	speed_t count;
	speed_t period;
	speed_t fetched;

	assign start_ok = slot_en && state == AXIS_IDLE && start && table_ready && step != '0;
	assign drive = slot_en && state == AXIS_RUN && !stop && count == speed_t'(1);
	assign last_pulse = (step_left == step_t'(1));
	assign next_index = (index < last_index) ? index + 1'b1 : last_index;	// hold last speed

	assign rd_req = start_ok || (drive && !last_pulse);
	assign rd_addr = start_ok ? '0 : next_index;

	assign fetched = (rd_data == '0) ? speed_t'(1) : rd_data;	// zero entry is one slot
	assign busy = (state != AXIS_IDLE);
	assign rt_speed = (state == AXIS_RUN) ? period : '0;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= AXIS_IDLE;
			req_d <= '0;
			dir <= 1'b0;
		end else begin
			req_d <= {req_d[0], rd_req};
			case (state)
				AXIS_IDLE: begin
					if (start_ok) begin
						state <= AXIS_FETCH;
						dir <= dir_in;
					end
				end
				AXIS_FETCH: begin
					if (slot_en && stop)
						state <= AXIS_IDLE;
					else if (req_d[1])
						state <= AXIS_RUN;
				end
				AXIS_RUN: begin
					if (slot_en && stop)
						state <= AXIS_IDLE;
					else if (drive && last_pulse)
						state <= AXIS_IDLE;
				end
				default: state <= AXIS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok) begin
			step_left <= step;
			index <= '0;
		end else if (drive) begin
			step_left <= step_left - 1'b1;
			index <= next_index;
		end
		if (req_d[1] && state != AXIS_IDLE) begin
			count <= fetched;	// reload lands before the next slot
			period <= fetched;
		end else if (slot_en && state == AXIS_RUN && count != speed_t'(1)) begin
			count <= count - 1'b1;
		end
	end

endmodule

// File: source/table_pkg.sv
`include "step_motor_cfg.svh"

package table_pkg;

	typedef logic [`TABLE_AW-1:0] table_addr_t;

	typedef enum logic [1:0] {
		LOAD_EMPTY,	// nothing written in this load
		LOAD_FILL,
		LOAD_READY
	} load_state_e;

endpackage

// File: step_motor.f
+incdir+source
source/motion_pkg.sv
source/table_pkg.sv
source/speed_table_loader.sv
source/speed_table_ram.sv
source/slot_scheduler.sv
source/step_pulse_gen.sv
source/step_motor.sv
bench/step_motor_props.sv
bench/step_motor_tb.sv
